// File: design/icache_defines.svh
/* icache geometry, RV32 opcodes, immediate widths and AXI4-Lite register offsets */

`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// cache geometry, one instruction per line
`define ICACHE_TAG_W   12
`define ICACHE_ENTRIES 256
`define ICACHE_ADDR_W  8

// word PC is tag plus index, at least 20 bits for the JAL low field
`define PC_W    20
`define INSTR_W 32

// predecoded immediates, byte granularity with bit 0 always zero
`define BIMM_W 13
`define JIMM_W 21

// RV32 major opcodes
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111

// register block byte offsets
`define AXIL_ADDR_W    4
`define REG_FILL_PC    4'h0
`define REG_FILL_INSTR 4'h4
`define REG_CTRL       4'h8
`define REG_MISS_CNT   4'hC

`endif

// File: design/icache_pkg.sv
/* icache types: instruction fields, cache line, fill write, AXI4-Lite channels,
   plus the branch and JAL immediate extract helpers shared by fill and fetch */

`include "icache_defines.svh"

package icache_pkg;

  // RV32 instruction, opcode in the low bits
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] op;
  } instr_s;

  // one cache line
  // sign and carry describe how to fix up the upper PC on fetch
  typedef struct packed {
    logic                     lower_sign;
    logic                     lower_cout;
    logic [`ICACHE_TAG_W-1:0] tag;
    instr_s                   instr;
  } icache_line_s;

  // fill write from the register block
  typedef struct packed {
    logic [`PC_W-1:0] pc;
    instr_s           instr;
  } icache_fill_s;

  // AXI4-Lite master to slave
  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] awaddr;
    logic                    awvalid;
    logic [31:0]             wdata;
    logic                    wvalid;
    logic                    bready;
    logic [`AXIL_ADDR_W-1:0] araddr;
    logic                    arvalid;
    logic                    rready;
  } axil_req_s;

  // AXI4-Lite slave to master
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } axil_rsp_s;

  // B-type immediate, {imm[12], imm[11], imm[10:5], imm[4:1], 0}
  function automatic logic [`BIMM_W-1:0] bimm_extract(instr_s i);
    logic [31:0] w;
    w = i;
    return {w[31], w[7], w[30:25], w[11:8], 1'b0};
  endfunction

  // J-type immediate, {imm[20], imm[19:12], imm[11], imm[10:1], 0}
  function automatic logic [`JIMM_W-1:0] jimm_extract(instr_s i);
    logic [31:0] w;
    w = i;
    return {w[31], w[19:12], w[20], w[30:21], 1'b0};
  endfunction

endpackage

// File: design/icache_mem.sv
/* single-port synchronous line memory
   read data is latched and held through write and idle cycles */

`include "icache_defines.svh"

module icache_mem
  import icache_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      v_i,
  input  logic                      w_i,
  input  logic [`ICACHE_ADDR_W-1:0] addr_i,
  input  icache_line_s              data_i,
  output icache_line_s              data_o
);

  icache_line_s mem_r [`ICACHE_ENTRIES];
  icache_line_s rdata_r;

  // array write
  always_ff @(posedge clk_i) begin
    if (v_i & w_i) begin
      mem_r[addr_i] <= data_i;
    end
  end

  // read port moves the output only on a read cycle
  // all-zero line after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdata_r <= '0;
    end else if (v_i & ~w_i) begin
      rdata_r <= mem_r[addr_i];
    end
  end

  assign data_o = rdata_r;

endmodule

// File: design/icache_predecode.sv
/* fill-side predecode: partial PC-relative target for branch and JAL,
   sum injected back into the immediate field with carry and sign */

`include "icache_defines.svh"

module icache_predecode
  import icache_pkg::*;
(
  input  icache_fill_s fill_i,
  output icache_line_s line_o
);

  localparam int PCB_W = `PC_W + 2;

  logic [PCB_W-1:0]         pc_byte;
  logic [`ICACHE_TAG_W-1:0] tag;
  logic                     is_branch;
  logic                     is_jal;

  logic [`BIMM_W-1:0] b_imm;
  logic [`BIMM_W-1:0] b_sum;
  logic               b_cout;
  logic [`JIMM_W-1:0] j_imm;
  logic [`JIMM_W-1:0] j_sum;
  logic               j_cout;

  logic [31:0] instr_in;
  logic [31:0] instr_inj;
  logic        imm_sign;
  logic        low_cout;

  // byte address of the filled word
  assign pc_byte = {fill_i.pc, 2'b00};
  assign tag     = fill_i.pc[`PC_W-1 -: `ICACHE_TAG_W];

  assign instr_in  = fill_i.instr;
  assign is_branch = (fill_i.instr.op == `OP_BRANCH);
  assign is_jal    = (fill_i.instr.op == `OP_JAL);

  assign b_imm = bimm_extract(fill_i.instr);
  assign j_imm = jimm_extract(fill_i.instr);

  // short adders only as wide as each immediate
  assign {b_cout, b_sum} = {1'b0, b_imm} + {1'b0, pc_byte[`BIMM_W-1:0]};
  assign {j_cout, j_sum} = {1'b0, j_imm} + {1'b0, pc_byte[`JIMM_W-1:0]};

  always_comb begin
    instr_inj = instr_in;
    imm_sign  = 1'b0;
    low_cout  = 1'b0;
    if (is_branch) begin
      // bits 12:1 of the sum go back in B-type order
      instr_inj[31]    = b_sum[12];
      instr_inj[7]     = b_sum[11];
      instr_inj[30:25] = b_sum[10:5];
      instr_inj[11:8]  = b_sum[4:1];
      imm_sign         = b_imm[`BIMM_W-1];
      low_cout         = b_cout;
    end else if (is_jal) begin
      // J-type scramble
      instr_inj[31]    = j_sum[20];
      instr_inj[19:12] = j_sum[19:12];
      instr_inj[20]    = j_sum[11];
      instr_inj[30:21] = j_sum[10:1];
      imm_sign         = j_imm[`JIMM_W-1];
      low_cout         = j_cout;
    end
  end

  assign line_o = '{
    lower_sign: imm_sign,
    lower_cout: low_cout,
    tag:        tag,
    instr:      instr_s'(instr_inj)
  };

endmodule

// File: design/icache_core.sv
/* icache fetch path: memory address select, registered PC and flush flag,
   target rebuild from the stored low sum, tag compare and miss pulse */

`include "icache_defines.svh"

module icache_core
  import icache_pkg::*;
(
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                fill_v_i,
  input  icache_fill_s        fill_i,
  input  logic                flush_i,
  input  logic                fetch_v_i,
  input  logic [`PC_W-1:0]    fetch_pc_i,
  input  logic [`PC_W-1:0]    jalr_pred_i,
  output logic [`INSTR_W-1:0] instr_o,
  output logic [`PC_W-1:0]    target_o,
  output logic [`PC_W-1:0]    pc_r_o,
  output logic                miss_o,
  output logic                flush_r_o,
  output logic                miss_v_o
);

  // upper byte-PC slices left over above each low sum
  localparam int PCB_W    = `PC_W + 2;
  localparam int BR_HI_W  = PCB_W - `BIMM_W;
  localparam int JAL_HI_W = PCB_W - `JIMM_W;

  icache_line_s              wr_line;
  icache_line_s              rd_line;
  logic                      mem_v;
  logic [`ICACHE_ADDR_W-1:0] mem_addr;
  logic                      fetch_acc;

  logic [`PC_W-1:0] pc_r;
  logic             flush_r;
  logic             fetch_acc_r;

  logic [BR_HI_W-1:0]  br_hi;
  logic [BR_HI_W-1:0]  br_hi_fix;
  logic [JAL_HI_W-1:0] jal_hi;
  logic [JAL_HI_W-1:0] jal_hi_fix;
  logic [PCB_W-1:0]    br_target;
  logic [PCB_W-1:0]    jal_target;
  logic                is_jal;
  logic                is_jalr;

  // fill wins, a colliding fetch is dropped and must be replayed
  assign fetch_acc = fetch_v_i & ~fill_v_i;
  assign mem_v     = fill_v_i | fetch_v_i;
  assign mem_addr  = fill_v_i ? fill_i.pc[`ICACHE_ADDR_W-1:0]
                              : fetch_pc_i[`ICACHE_ADDR_W-1:0];

  icache_predecode u_predecode (
    .fill_i (fill_i),
    .line_o (wr_line)
  );

  icache_mem u_mem (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (mem_v),
    .w_i     (fill_v_i),
    .addr_i  (mem_addr),
    .data_i  (wr_line),
    .data_o  (rd_line)
  );

  // pc and flush flag move together with the memory read
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_r        <= '0;
      flush_r     <= 1'b0;
      fetch_acc_r <= 1'b0;
    end else begin
      fetch_acc_r <= fetch_acc;
      if (fetch_acc) begin
        pc_r    <= fetch_pc_i;
        flush_r <= 1'b0;
      end else begin
        // sticky until the next real fetch
        flush_r <= flush_r | flush_i;
      end
    end
  end

  assign br_hi  = pc_r[`PC_W-1 -: BR_HI_W];
  assign jal_hi = pc_r[`PC_W-1 -: JAL_HI_W];

  // sign vs carry of the low sum picks high, high+1 or high-1
  always_comb begin
    case ({rd_line.lower_sign, rd_line.lower_cout})
      2'b01: begin
        br_hi_fix  = br_hi + 1'b1;
        jal_hi_fix = jal_hi + 1'b1;
      end
      2'b10: begin
        br_hi_fix  = br_hi - 1'b1;
        jal_hi_fix = jal_hi - 1'b1;
      end
      default: begin
        br_hi_fix  = br_hi;
        jal_hi_fix = jal_hi;
      end
    endcase
  end

  // byte targets
  assign br_target  = {br_hi_fix, bimm_extract(rd_line.instr)};
  assign jal_target = {jal_hi_fix, jimm_extract(rd_line.instr)};

  assign is_jal  = (rd_line.instr.op == `OP_JAL);
  assign is_jalr = (rd_line.instr.op == `OP_JALR);

  // word target out
  assign target_o = is_jal  ? jal_target[PCB_W-1:2] :
                    is_jalr ? jalr_pred_i :
                              br_target[PCB_W-1:2];

  assign instr_o   = rd_line.instr;
  assign pc_r_o    = pc_r;
  assign flush_r_o = flush_r;
  assign miss_o    = (rd_line.tag != pc_r[`PC_W-1 -: `ICACHE_TAG_W]);

  // one pulse per fetch result that missed
  assign miss_v_o = fetch_acc_r & miss_o;

endmodule

// File: design/icache_axil_regs.sv
/* AXI4-Lite register block: fill PC, fill instruction, flush control
   and a read-only miss counter */

`include "icache_defines.svh"

module icache_axil_regs
  import icache_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  axil_req_s    axil_req_i,
  output axil_rsp_s    axil_rsp_o,
  input  logic         miss_v_i,
  output logic         fill_v_o,
  output icache_fill_s fill_o,
  output logic         flush_o
);

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic                  wr_start;
  logic                  rd_start;
  logic                  wr_mapped;
  logic                  rd_mapped;
  logic [31:0]           rd_word;

  logic                  awready_r;
  logic                  bvalid_r;
  logic [1:0]            bresp_r;
  logic                  arready_r;
  logic                  rvalid_r;
  logic [1:0]            rresp_r;
  logic [31:0]           rdata_r;
  logic                  fill_v_r;
  logic                  flush_r;
  logic [`PC_W-1:0]      fill_pc_r;
  logic [`INSTR_W-1:0]   fill_instr_r;
  logic [31:0]           miss_cnt_r;

  // address and data must both be present
  // held off while a write response is still pending
  assign wr_start = axil_req_i.awvalid & axil_req_i.wvalid & ~awready_r & ~bvalid_r;
  assign rd_start = axil_req_i.arvalid & ~arready_r & ~rvalid_r;

  // only word-aligned offsets are mapped
  assign wr_mapped = (axil_req_i.awaddr[1:0] == 2'b00);
  assign rd_mapped = (axil_req_i.araddr[1:0] == 2'b00);

  // write channel
  // side effects fire in the cycle awready and wready are high
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      awready_r <= 1'b0;
      bvalid_r  <= 1'b0;
      fill_v_r  <= 1'b0;
      flush_r   <= 1'b0;
      fill_pc_r <= '0;
    end else begin
      awready_r <= wr_start;
      fill_v_r  <= wr_start & (axil_req_i.awaddr == `REG_FILL_INSTR);
      flush_r   <= wr_start & (axil_req_i.awaddr == `REG_CTRL) & axil_req_i.wdata[0];
      if (wr_start & (axil_req_i.awaddr == `REG_FILL_PC)) begin
        fill_pc_r <= axil_req_i.wdata[`PC_W-1:0];
      end
      if (awready_r) begin
        bvalid_r <= 1'b1;
      end else if (axil_req_i.bready) begin
        bvalid_r <= 1'b0;
      end
    end
  end

  // write payload
  always_ff @(posedge clk_i) begin
    if (wr_start) begin
      bresp_r <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
      if (axil_req_i.awaddr == `REG_FILL_INSTR) begin
        fill_instr_r <= axil_req_i.wdata;
      end
    end
  end

  // miss counter, wraps, writes to it are dropped
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      miss_cnt_r <= '0;
    end else if (miss_v_i) begin
      miss_cnt_r <= miss_cnt_r + 32'd1;
    end
  end

  // read mux
  always_comb begin
    case (axil_req_i.araddr)
      `REG_FILL_PC:    rd_word = 32'(fill_pc_r);
      `REG_FILL_INSTR: rd_word = fill_instr_r;
      `REG_MISS_CNT:   rd_word = miss_cnt_r;
      default:         rd_word = '0;
    endcase
  end

  // read channel
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      arready_r <= 1'b0;
      rvalid_r  <= 1'b0;
    end else begin
      arready_r <= rd_start;
      if (arready_r) begin
        rvalid_r <= 1'b1;
      end else if (axil_req_i.rready) begin
        rvalid_r <= 1'b0;
      end
    end
  end

  // data captured at the address handshake
  always_ff @(posedge clk_i) begin
    if (arready_r) begin
      rdata_r <= rd_mapped ? rd_word : '0;
      rresp_r <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
    end
  end

  assign axil_rsp_o = '{
    awready: awready_r,
    wready:  awready_r,
    bresp:   bresp_r,
    bvalid:  bvalid_r,
    arready: arready_r,
    rdata:   rdata_r,
    rresp:   rresp_r,
    rvalid:  rvalid_r
  };

  assign fill_v_o = fill_v_r;
  assign fill_o   = '{pc: fill_pc_r, instr: fill_instr_r};
  assign flush_o  = flush_r;

endmodule

// File: design/icache_top.sv
/* icache top: AXI4-Lite register block beside the cache core */

`include "icache_defines.svh"

module icache_top
  import icache_pkg::*;
(
  input  logic                clk_i,
  input  logic                reset_i,
  input  axil_req_s           axil_req_i,
  output axil_rsp_s           axil_rsp_o,
  input  logic                fetch_v_i,
  input  logic [`PC_W-1:0]    fetch_pc_i,
  input  logic [`PC_W-1:0]    jalr_pred_i,
  output logic [`INSTR_W-1:0] instr_o,
  output logic [`PC_W-1:0]    target_o,
  output logic [`PC_W-1:0]    pc_r_o,
  output logic                miss_o,
  output logic                flush_r_o
);

  // register block to core
  logic         fill_v;
  icache_fill_s fill;
  logic         flush;
  // core back to counter
  logic         miss_v;

  icache_axil_regs u_regs (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .miss_v_i   (miss_v),
    .fill_v_o   (fill_v),
    .fill_o     (fill),
    .flush_o    (flush)
  );

  icache_core u_core (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .fill_v_i    (fill_v),
    .fill_i      (fill),
    .flush_i     (flush),
    .fetch_v_i   (fetch_v_i),
    .fetch_pc_i  (fetch_pc_i),
    .jalr_pred_i (jalr_pred_i),
    .instr_o     (instr_o),
    .target_o    (target_o),
    .pc_r_o      (pc_r_o),
    .miss_o      (miss_o),
    .flush_r_o   (flush_r_o),
    .miss_v_o    (miss_v)
  );

endmodule

// File: verif/tb_clk_gen.sv
/* testbench clock source, free running from time zero */

module tb_clk_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
  end

  // half period per toggle
  always begin
    #(PERIOD_NS / 2);
    clk_o = ~clk_o;
  end

endmodule

// File: verif/icache_tb.sv
/* icache testbench: AXI4-Lite register tasks, fetch task, target model,
   stimulus table, miss counter, flush and register map checks */

`include "icache_defines.svh"

module icache_tb
  import icache_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 50;

  // flag bits {do_fill, exp_miss, chk_instr, chk_target, is_jalr}
  localparam logic [4:0] F_WORD = 5'b10100;
  localparam logic [4:0] F_TGT  = 5'b10010;
  localparam logic [4:0] F_JALR = 5'b10011;
  localparam logic [4:0] F_MISS = 5'b01000;
  localparam logic [4:0] F_HIT  = 5'b00100;

  // one stimulus row with imm as the byte offset
  typedef struct packed {
    logic [`PC_W-1:0] fill_pc;
    logic [31:0]      instr;
    logic [31:0]      imm;
    logic [`PC_W-1:0] fetch_pc;
    logic [`PC_W-1:0] jalr_pred;
    logic             do_fill;
    logic             exp_miss;
    logic             chk_instr;
    logic             chk_target;
    logic             is_jalr;
  } vec_s;

  logic             clk;
  logic             reset;
  axil_req_s        axil_req;
  axil_rsp_s        axil_rsp;
  logic             fetch_v;
  logic [`PC_W-1:0] fetch_pc;
  logic [`PC_W-1:0] jalr_pred;
  logic [31:0]      instr;
  logic [`PC_W-1:0] target;
  logic [`PC_W-1:0] pc_r;
  logic             miss;
  logic             flush_r;

  vec_s        vec_q[$];
  integer      seed;
  logic [31:0] last_instr;

  tb_clk_gen u_clk (
    .clk_o (clk)
  );

  icache_top u_icache_top (
    .clk_i       (clk),
    .reset_i     (reset),
    .axil_req_i  (axil_req),
    .axil_rsp_o  (axil_rsp),
    .fetch_v_i   (fetch_v),
    .fetch_pc_i  (fetch_pc),
    .jalr_pred_i (jalr_pred),
    .instr_o     (instr),
    .target_o    (target),
    .pc_r_o      (pc_r),
    .miss_o      (miss),
    .flush_r_o   (flush_r)
  );

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("ERR time=%0t %s got=0x%08h exp=0x%08h", $time, name, got, exp));
    end
  endtask

  // RV32 encoders with B-type and J-type immediate scramble
  function automatic logic [31:0] branch_word(input logic [31:0] imm);
    return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], `OP_BRANCH};
  endfunction

  function automatic logic [31:0] jal_word(input logic [31:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, `OP_JAL};
  endfunction

  function automatic logic [31:0] jalr_word();
    return {12'h000, 5'd1, 3'b000, 5'd0, `OP_JALR};
  endfunction

  // reference target is word PC plus byte offset over 4
  function automatic logic [`PC_W-1:0] model_target(input vec_s v);
    logic [31:0] word_off;
    if (v.is_jalr) begin
      return v.jalr_pred;
    end
    word_off = $signed(v.imm) >>> 2;
    return v.fetch_pc + word_off[`PC_W-1:0];
  endfunction

  function automatic void add_vec(input logic [`PC_W-1:0] f_pc, input logic [31:0] word,
                                  input logic [31:0] imm, input logic [`PC_W-1:0] x_pc,
                                  input logic [`PC_W-1:0] pred, input logic [4:0] flags);
    vec_s v;
    v.fill_pc    = f_pc;
    v.instr      = word;
    v.imm        = imm;
    v.fetch_pc   = x_pc;
    v.jalr_pred  = pred;
    v.do_fill    = flags[4];
    v.exp_miss   = flags[3];
    v.chk_instr  = flags[2];
    v.chk_target = flags[1];
    v.is_jalr    = flags[0];
    vec_q.push_back(v);
  endfunction

  function automatic void build_table();
    logic [31:0]      rnd;
    logic [31:0]      word;
    logic [`PC_W-1:0] pc;
    // plain ALU words add and addi
    add_vec(20'h00010, 32'h002081B3, 0, 20'h00010, '0, F_WORD);
    add_vec(20'h12345, 32'h00A50513, 0, 20'h12345, '0, F_WORD);
    // small and negative branches, carry across bit 13 both ways and range limits
    add_vec(20'h00020, branch_word(16), 16, 20'h00020, '0, F_TGT);
    add_vec(20'h00100, branch_word(-64), -64, 20'h00100, '0, F_TGT);
    add_vec(20'h007FE, branch_word(16), 16, 20'h007FE, '0, F_TGT);
    add_vec(20'h00801, branch_word(-32), -32, 20'h00801, '0, F_TGT);
    add_vec(20'h05000, branch_word(-4096), -4096, 20'h05000, '0, F_TGT);
    add_vec(20'h0A7FF, branch_word(4092), 4092, 20'h0A7FF, '0, F_TGT);
    // jal carry into the top bit and wrap at both ends of the PC space
    add_vec(20'h00040, jal_word(32'h1000), 32'h1000, 20'h00040, '0, F_TGT);
    add_vec(20'h23456, jal_word(-32'h40000), -32'h40000, 20'h23456, '0, F_TGT);
    add_vec(20'h7FFF0, jal_word(32'h100), 32'h100, 20'h7FFF0, '0, F_TGT);
    add_vec(20'hFFFE8, jal_word(32'h80), 32'h80, 20'hFFFE8, '0, F_TGT);
    add_vec(20'h00004, jal_word(-32), -32, 20'h00004, '0, F_TGT);
    // jalr takes the external prediction
    add_vec(20'h00050, jalr_word(), 0, 20'h00050, 20'hABCDE, F_JALR);
    // random non-branch words on indices 0x80 and up
    for (int k = 0; k < 6; k++) begin
      rnd  = $random(seed);
      pc   = {rnd[31:20], 8'h80 + 8'(k)};
      rnd  = $random(seed);
      word = {rnd[31:7], 7'b0110011};
      add_vec(pc, word, 0, pc, '0, F_WORD);
    end
    // same index with another tag
    add_vec('0, '0, 0, 20'h01010, '0, F_MISS);
    add_vec('0, '0, 0, 20'h55345, '0, F_MISS);
    // original line still there
    add_vec('0, 32'h002081B3, 0, 20'h00010, '0, F_HIT);
  endfunction

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    @(negedge clk);
    axil_req.awaddr  = addr;
    axil_req.awvalid = 1'b1;
    axil_req.wdata   = data;
    axil_req.wvalid  = 1'b1;
    axil_req.bready  = 1'b1;
    // awready and wready rise together
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) begin
        fail_stop("timeout waiting for the write address and data handshake");
      end
    end while (!(axil_rsp.awready && axil_rsp.wready));
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    n = 0;
    while (!axil_rsp.bvalid) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) begin
        fail_stop("timeout waiting for the write response");
      end
    end
    resp = axil_rsp.bresp;
    // bvalid drops on the next edge
    @(negedge clk);
    axil_req.bready = 1'b0;
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    @(negedge clk);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    axil_req.rready  = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) begin
        fail_stop("timeout waiting for arready on a register read");
      end
    end while (!axil_rsp.arready);
    // araddr stays put while data is taken in the arready cycle
    axil_req.arvalid = 1'b0;
    n = 0;
    while (!axil_rsp.rvalid) begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) begin
        fail_stop("timeout waiting for read data");
      end
    end
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(negedge clk);
    axil_req.rready = 1'b0;
  endtask

  task automatic fill_line(input logic [`PC_W-1:0] pc, input logic [31:0] word);
    logic [1:0] resp;
    write_reg(`REG_FILL_PC, 32'(pc), resp);
    check_val("bresp", resp, 2'b00);
    write_reg(`REG_FILL_INSTR, word, resp);
    check_val("bresp", resp, 2'b00);
    last_instr = word;
  endtask

  // one-cycle fetch with the result sampled on the next falling edge
  task automatic fetch_word(input logic [`PC_W-1:0] pc, input logic [`PC_W-1:0] pred);
    @(negedge clk);
    fetch_v   = 1'b1;
    fetch_pc  = pc;
    jalr_pred = pred;
    @(negedge clk);
    fetch_v = 1'b0;
  endtask

  initial begin
    vec_s        v;
    logic [31:0] rdata;
    logic [1:0]  resp;
    int          miss_cnt;

    reset      = 1'b1;
    axil_req   = '0;
    fetch_v    = 1'b0;
    fetch_pc   = '0;
    jalr_pred  = '0;
    seed       = 20959;
    miss_cnt   = 0;
    last_instr = '0;
    build_table();

    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // reset state
    check_val("pc_r_o", pc_r, 0);
    check_val("flush_r_o", flush_r, 0);
    check_val("awready", axil_rsp.awready, 0);
    check_val("wready", axil_rsp.wready, 0);
    check_val("arready", axil_rsp.arready, 0);
    check_val("bvalid", axil_rsp.bvalid, 0);
    check_val("rvalid", axil_rsp.rvalid, 0);

    // stimulus table
    foreach (vec_q[i]) begin
      v = vec_q[i];
      if (v.do_fill) begin
        fill_line(v.fill_pc, v.instr);
      end
      fetch_word(v.fetch_pc, v.jalr_pred);
      check_val("pc_r_o", pc_r, v.fetch_pc);
      check_val("miss_o", miss, v.exp_miss);
      if (v.chk_instr) begin
        check_val("instr_o", instr, v.instr);
      end
      if (v.chk_target) begin
        check_val("target_o", target, model_target(v));
      end
      if (v.exp_miss) begin
        miss_cnt++;
      end
    end

    // miss counter unchanged by a write
    read_reg(`REG_MISS_CNT, rdata, resp);
    check_val("rresp", resp, 2'b00);
    check_val("miss_cnt", rdata, miss_cnt);
    write_reg(`REG_MISS_CNT, 32'h0000_0055, resp);
    check_val("bresp", resp, 2'b00);
    read_reg(`REG_MISS_CNT, rdata, resp);
    check_val("miss_cnt", rdata, miss_cnt);

    // flush flag sticks until the next fetch
    check_val("flush_r_o", flush_r, 0);
    write_reg(`REG_CTRL, 32'h1, resp);
    check_val("bresp", resp, 2'b00);
    check_val("flush_r_o", flush_r, 1);
    repeat (6) @(negedge clk);
    check_val("flush_r_o", flush_r, 1);
    fetch_word(20'h00010, '0);
    check_val("flush_r_o", flush_r, 0);
    check_val("pc_r_o", pc_r, 20'h00010);

    // register map readback and error responses
    write_reg(`REG_FILL_PC, 32'h0009_ABCD, resp);
    check_val("bresp", resp, 2'b00);
    read_reg(`REG_FILL_PC, rdata, resp);
    check_val("rresp", resp, 2'b00);
    check_val("fill_pc", rdata, 32'h0009_ABCD);
    read_reg(`REG_FILL_INSTR, rdata, resp);
    check_val("fill_instr", rdata, last_instr);
    read_reg(4'h6, rdata, resp);
    check_val("rresp", resp, 2'b10);
    check_val("rdata", rdata, 0);
    write_reg(4'h3, 32'hFFFF_FFFF, resp);
    check_val("bresp", resp, 2'b10);

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: src.f
+incdir+design
design/icache_pkg.sv
design/icache_mem.sv
design/icache_predecode.sv
design/icache_core.sv
design/icache_axil_regs.sv
design/icache_top.sv
verif/tb_clk_gen.sv
verif/icache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the icache testbench with Verilator
# the simulation log is searched for the fail message

verilator --binary --timing -Wno-fatal --top-module icache_tb -f src.f -o icache_sim \
  > build.log 2>&1 \
  && ./obj_dir/icache_sim > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; } \
  || { echo "simulation passed"; exit 0; }
